// File: rtl/core_isa_pkg.sv
package core_isa_pkg;

    // datapath and register index widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [0:0] {
        UNIT_ALU = 1'b0,
        UNIT_DIV = 1'b1
    } exe_unit_e;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLT    = 5'd2,
        ALU_SLTU   = 5'd3,
        ALU_AND    = 5'd4,
        ALU_OR     = 5'd5,
        ALU_NOR    = 5'd6,
        ALU_XOR    = 5'd7,
        ALU_SLL    = 5'd8,
        ALU_SRL    = 5'd9,
        ALU_SRA    = 5'd10,
        ALU_PASS_B = 5'd11
    } alu_op_e;

    // divider view of the sub-operation field
    typedef struct packed {
        logic [2:0] pad;
        logic       is_unsigned;
        logic       is_mod;
    } div_op_t;

    // alu view when unit is ALU, div view when unit is DIV
    typedef union packed {
        alu_op_e alu;
        div_op_t div;
    } sub_op_u;

    typedef enum logic [0:0] {
        SRC1_RJ = 1'b0,
        SRC1_PC = 1'b1
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RK   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_FOUR = 2'd2
    } src2_sel_e;

endpackage

// File: rtl/core_pipe_pkg.sv
package core_pipe_pkg;

    // one decoded operation as presented by the source
    typedef struct packed {
        logic [core_isa_pkg::XLEN-1:0]   pc;
        core_isa_pkg::exe_unit_e         unit;
        core_isa_pkg::sub_op_u           sub;
        core_isa_pkg::src1_sel_e         src1;
        core_isa_pkg::src2_sel_e         src2;
        logic [core_isa_pkg::REG_AW-1:0] rj;
        logic [core_isa_pkg::REG_AW-1:0] rk;
        logic [core_isa_pkg::REG_AW-1:0] rd;
        logic [core_isa_pkg::XLEN-1:0]   imm;
        logic                            wen;
    } issue_op_t;

    // X0 stage contents
    typedef struct packed {
        logic      valid;
        issue_op_t op;
    } stage_x0_t;

    // X1 and WB carry only what retirement needs
    typedef struct packed {
        logic                            valid;
        logic [core_isa_pkg::XLEN-1:0]   pc;
        logic [core_isa_pkg::REG_AW-1:0] rd;
        logic                            wen;
        logic [core_isa_pkg::XLEN-1:0]   result;
    } stage_res_t;

    // writeback debug bundle, byte enables replicated
    typedef struct packed {
        logic [core_isa_pkg::XLEN-1:0]   pc;
        logic [3:0]                      rf_wen;
        logic [core_isa_pkg::REG_AW-1:0] rf_wnum;
        logic [core_isa_pkg::XLEN-1:0]   rf_wdata;
    } wb_debug_t;

endpackage

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [core_isa_pkg::REG_AW-1:0] rj,
    input  logic [core_isa_pkg::REG_AW-1:0] rk,
    input  core_pipe_pkg::stage_res_t       wb,
    output logic [core_isa_pkg::XLEN-1:0]   rj_data,
    output logic [core_isa_pkg::XLEN-1:0]   rk_data
);

    localparam int NREG = 2 ** core_isa_pkg::REG_AW;

    // r0 has no storage
    logic [core_isa_pkg::XLEN-1:0] regs [1:NREG-1];
    logic                          wr_en;

    assign wr_en = wb.valid && wb.wen && (wb.rd != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // combinational reads
    assign rj_data = (rj == '0) ? '0 : regs[rj];
    assign rk_data = (rk == '0) ? '0 : regs[rk];

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  core_pipe_pkg::stage_x0_t      x0,
    input  core_pipe_pkg::stage_res_t     x1,
    input  core_pipe_pkg::stage_res_t     wb,
    input  logic [core_isa_pkg::XLEN-1:0] rj_data,
    input  logic [core_isa_pkg::XLEN-1:0] rk_data,
    output logic [core_isa_pkg::XLEN-1:0] src_a,
    output logic [core_isa_pkg::XLEN-1:0] src_b,
    output logic [core_isa_pkg::XLEN-1:0] rj_val,
    output logic [core_isa_pkg::XLEN-1:0] rk_val
);

    // youngest producer wins, r0 is always zero
    function automatic logic [core_isa_pkg::XLEN-1:0] fwd(
        input logic [core_isa_pkg::REG_AW-1:0] idx,
        input logic [core_isa_pkg::XLEN-1:0]   rf_val,
        input core_pipe_pkg::stage_res_t       s_x1,
        input core_pipe_pkg::stage_res_t       s_wb
    );
        if (idx == '0) begin
            fwd = '0;
        end else if (s_x1.valid && s_x1.wen && (s_x1.rd == idx)) begin
            fwd = s_x1.result;
        end else if (s_wb.valid && s_wb.wen && (s_wb.rd == idx)) begin
            fwd = s_wb.result;
        end else begin
            fwd = rf_val;
        end
    endfunction

    assign rj_val = fwd(x0.op.rj, rj_data, x1, wb);
    assign rk_val = fwd(x0.op.rk, rk_data, x1, wb);

    always_comb begin
        case (x0.op.src1)
            core_isa_pkg::SRC1_PC: src_a = x0.op.pc;
            default:               src_a = rj_val;
        endcase
    end

    always_comb begin
        case (x0.op.src2)
            core_isa_pkg::SRC2_RK:   src_b = rk_val;
            core_isa_pkg::SRC2_IMM:  src_b = x0.op.imm;
            core_isa_pkg::SRC2_FOUR: src_b = core_isa_pkg::XLEN'(4);
            default:                 src_b = '0;
        endcase
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_isa_pkg::alu_op_e         op,
    input  logic [core_isa_pkg::XLEN-1:0] a,
    input  logic [core_isa_pkg::XLEN-1:0] b,
    output logic [core_isa_pkg::XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // shift amount from the low bits of b only
    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            core_isa_pkg::ALU_ADD:    result = a + b;
            core_isa_pkg::ALU_SUB:    result = a - b;
            core_isa_pkg::ALU_SLT:    result = {{(core_isa_pkg::XLEN-1){1'b0}}, lt_s};
            core_isa_pkg::ALU_SLTU:   result = {{(core_isa_pkg::XLEN-1){1'b0}}, lt_u};
            core_isa_pkg::ALU_AND:    result = a & b;
            core_isa_pkg::ALU_OR:     result = a | b;
            core_isa_pkg::ALU_NOR:    result = ~(a | b);
            core_isa_pkg::ALU_XOR:    result = a ^ b;
            core_isa_pkg::ALU_SLL:    result = a << shamt;
            core_isa_pkg::ALU_SRL:    result = a >> shamt;
            core_isa_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            core_isa_pkg::ALU_PASS_B: result = b;
            default:                  result = '0;
        endcase
    end

endmodule

// File: rtl/div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl #(
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  core_pipe_pkg::stage_x0_t x0,
    output logic                     start,
    output logic                     step,
    output logic                     stall,
    output logic                     div_sel
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    logic             div_op;

    // only place where the unit field is decoded
    assign div_op  = x0.valid && (x0.op.unit == core_isa_pkg::UNIT_DIV);
    assign div_sel = div_op;

    assign start = (state == IDLE) && div_op;
    assign step  = (state == RUN);
    // released in DONE so X0 can advance with the result
    assign stall = div_op && (state != DONE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        cnt   <= CNT_W'(WIDTH);
                    end
                end
                RUN: begin
                    cnt <= cnt - 1'b1;
                    // last iteration
                    if (cnt == CNT_W'(1)) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/div_datapath.sv
`timescale 1ns/1ps

module div_datapath #(
    parameter int WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,
    input  logic                  step,
    input  core_isa_pkg::div_op_t sub,
    input  logic [WIDTH-1:0]      dividend,
    input  logic [WIDTH-1:0]      divisor,
    output logic [WIDTH-1:0]      result
);

    logic             a_neg;
    logic             b_neg;
    logic [WIDTH-1:0] a_mag;
    logic [WIDTH-1:0] b_mag;
    logic [WIDTH-1:0] quo;
    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] dvs;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   diff;
    logic             neg_q;
    logic             neg_r;
    logic             div_zero;
    logic             is_mod;
    logic [WIDTH-1:0] q_out;
    logic [WIDTH-1:0] r_out;

    // operand magnitudes, signed ops only
    assign a_neg = !sub.is_unsigned && dividend[WIDTH-1];
    assign b_neg = !sub.is_unsigned && divisor[WIDTH-1];
    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    // one restoring step: shift in next dividend bit, trial subtract
    assign shifted = {rem, quo[WIDTH-1]};
    assign diff    = shifted - {1'b0, dvs};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            div_zero <= 1'b0;
            is_mod   <= 1'b0;
        end else if (start) begin
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;
            div_zero <= (divisor == '0);
            is_mod   <= sub.is_mod;
        end
    end

    // quo doubles as the dividend shift register
    always_ff @(posedge clk) begin
        if (start) begin
            quo <= a_mag;
            rem <= '0;
            dvs <= b_mag;
        end else if (step) begin
            if (!diff[WIDTH]) begin
                rem <= diff[WIDTH-1:0];
                quo <= {quo[WIDTH-2:0], 1'b1};
            end else begin
                rem <= shifted[WIDTH-1:0];
                quo <= {quo[WIDTH-2:0], 1'b0};
            end
        end
    end

    // truncating division, remainder follows dividend sign
    // divide by zero leaves rem = |dividend|, so sign fix restores the dividend
    assign q_out  = div_zero ? '1 : (neg_q ? -quo : quo);
    assign r_out  = neg_r ? -rem : rem;
    assign result = is_mod ? r_out : q_out;

endmodule

// File: rtl/exe_pipe.sv
`timescale 1ns/1ps

module exe_pipe (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          op_valid,
    input  core_pipe_pkg::issue_op_t      op,
    input  logic                          stall,
    input  logic                          div_sel,
    input  logic [core_isa_pkg::XLEN-1:0] alu_result,
    input  logic [core_isa_pkg::XLEN-1:0] div_result,
    output core_pipe_pkg::stage_x0_t      x0,
    output core_pipe_pkg::stage_res_t     x1,
    output core_pipe_pkg::stage_res_t     wb
);

    logic [core_isa_pkg::XLEN-1:0] x1_result;

    assign x1_result = div_sel ? div_result : alu_result;

    // X0 holds while the divider is busy
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x0 <= '0;
        end else if (!stall) begin
            x0.valid <= op_valid;
            x0.op    <= op;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x1 <= '0;
        end else if (stall) begin
            // bubble, payload left as is
            x1.valid <= 1'b0;
        end else begin
            x1.valid  <= x0.valid;
            x1.pc     <= x0.op.pc;
            x1.rd     <= x0.op.rd;
            x1.wen    <= x0.op.wen;
            x1.result <= x1_result;
        end
    end

    // WB always drains
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb <= '0;
        end else begin
            wb <= x1;
        end
    end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     op_valid,
    input  core_pipe_pkg::issue_op_t op,
    output logic                     stall,
    output core_pipe_pkg::wb_debug_t wb_dbg
);

    localparam int DIV_WIDTH = core_isa_pkg::XLEN;

    core_pipe_pkg::stage_x0_t      x0;
    core_pipe_pkg::stage_res_t     x1;
    core_pipe_pkg::stage_res_t     wb;
    logic [core_isa_pkg::XLEN-1:0] rj_data;
    logic [core_isa_pkg::XLEN-1:0] rk_data;
    logic [core_isa_pkg::XLEN-1:0] src_a;
    logic [core_isa_pkg::XLEN-1:0] src_b;
    logic [core_isa_pkg::XLEN-1:0] rj_val;
    logic [core_isa_pkg::XLEN-1:0] rk_val;
    logic [core_isa_pkg::XLEN-1:0] alu_result;
    logic [core_isa_pkg::XLEN-1:0] div_result;
    logic                          start;
    logic                          step;
    logic                          div_sel;

    exe_pipe u_exe_pipe (
        .clk        (clk),
        .rstn       (rstn),
        .op_valid   (op_valid),
        .op         (op),
        .stall      (stall),
        .div_sel    (div_sel),
        .alu_result (alu_result),
        .div_result (div_result),
        .x0         (x0),
        .x1         (x1),
        .wb         (wb)
    );

    regfile u_regfile (
        .clk     (clk),
        .rstn    (rstn),
        .rj      (x0.op.rj),
        .rk      (x0.op.rk),
        .wb      (wb),
        .rj_data (rj_data),
        .rk_data (rk_data)
    );

    operand_select u_operand_select (
        .x0      (x0),
        .x1      (x1),
        .wb      (wb),
        .rj_data (rj_data),
        .rk_data (rk_data),
        .src_a   (src_a),
        .src_b   (src_b),
        .rj_val  (rj_val),
        .rk_val  (rk_val)
    );

    alu u_alu (
        .op     (x0.op.sub.alu),
        .a      (src_a),
        .b      (src_b),
        .result (alu_result)
    );

    div_ctrl #(
        .WIDTH (DIV_WIDTH)
    ) u_div_ctrl (
        .clk     (clk),
        .rstn    (rstn),
        .x0      (x0),
        .start   (start),
        .step    (step),
        .stall   (stall),
        .div_sel (div_sel)
    );

    div_datapath #(
        .WIDTH (DIV_WIDTH)
    ) u_div_datapath (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .step     (step),
        .sub      (x0.op.sub.div),
        .dividend (rj_val),
        .divisor  (rk_val),
        .result   (div_result)
    );

    // debug view of the retiring write
    assign wb_dbg.pc       = wb.pc;
    assign wb_dbg.rf_wen   = {4{wb.valid && wb.wen && (wb.rd != '0)}};
    assign wb_dbg.rf_wnum  = wb.rd;
    assign wb_dbg.rf_wdata = wb.result;

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam logic U_ALU = 1'b0;
    localparam logic U_DIV = 1'b1;
    // divider sub-op encodings as {pad, is_unsigned, is_mod}
    localparam logic [4:0] D_DIV  = 5'b00000;
    localparam logic [4:0] D_MOD  = 5'b00001;
    localparam logic [4:0] D_DIVU = 5'b00010;
    localparam logic [4:0] D_MODU = 5'b00011;
    localparam logic [31:0] PC_BASE = 32'h1c00_0000;
    localparam int LIMIT = 200;

    typedef struct {
        int                       test;
        core_pipe_pkg::issue_op_t op;
        logic [4:0]               wnum;
        logic [31:0]              wdata;
        int                       gap;
        bit                       rnd;
    } entry_t;

    logic                     clk;
    logic                     rstn;
    logic                     op_valid;
    core_pipe_pkg::issue_op_t op;
    logic                     stall;
    core_pipe_pkg::wb_debug_t wb_dbg;

    entry_t      table_q[$];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_num[$];
    logic [31:0] exp_data[$];
    int          errors;
    int          cycle;
    int          first_wb_cycle;
    int          acc_cycle;
    int          stall_seen;
    int          tests_passed;

    core_top uut (
        .clk      (clk),
        .rstn     (rstn),
        .op_valid (op_valid),
        .op       (op),
        .stall    (stall),
        .wb_dbg   (wb_dbg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // writeback monitor sampling mid-cycle
    always @(negedge clk) begin
        if (rstn && wb_dbg.rf_wen != 4'h0) begin
            if (first_wb_cycle < 0) first_wb_cycle = cycle;
            if (exp_num.size() == 0) begin
                $display("unexpected writeback to r%0d with no write pending", wb_dbg.rf_wnum);
                errors++;
            end else begin
                if (wb_dbg.rf_wen != 4'hf) begin
                    $display("MISMATCH rf_wen exp 0xf got 0x%h", wb_dbg.rf_wen);
                    errors++;
                end
                if (wb_dbg.rf_wnum != exp_num[0]) begin
                    $display("MISMATCH rf_wnum exp 0x%h got 0x%h", exp_num[0], wb_dbg.rf_wnum);
                    errors++;
                end
                if (wb_dbg.rf_wdata != exp_data[0]) begin
                    $display("MISMATCH rf_wdata exp 0x%h got 0x%h",
                             exp_data[0], wb_dbg.rf_wdata);
                    errors++;
                end
                if (wb_dbg.pc != exp_pc[0]) begin
                    $display("MISMATCH pc exp 0x%h got 0x%h", exp_pc[0], wb_dbg.pc);
                    errors++;
                end
                void'(exp_pc.pop_front());
                void'(exp_num.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic timeout(input string what);
        $display("timeout after %0d cycles while %s", LIMIT, what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // columns are test, unit, sub, src1, src2, rj, rk, rd, imm, wnum, wdata, gap, random gap
    task automatic add(input int test, input logic unit, input logic [4:0] sub,
                       input logic s1, input logic [1:0] s2, input logic [4:0] rj,
                       input logic [4:0] rk, input logic [4:0] rd, input logic [31:0] imm,
                       input logic [4:0] wnum, input logic [31:0] wdata,
                       input int gap, input bit rnd);
        entry_t e;
        e.test     = test;
        e.op.pc    = PC_BASE + 32'(4 * table_q.size());
        e.op.unit  = core_isa_pkg::exe_unit_e'(unit);
        e.op.sub   = sub;
        e.op.src1  = core_isa_pkg::src1_sel_e'(s1);
        e.op.src2  = core_isa_pkg::src2_sel_e'(s2);
        e.op.rj    = rj;
        e.op.rk    = rk;
        e.op.rd    = rd;
        e.op.imm   = imm;
        e.op.wen   = 1'b1;
        e.wnum     = wnum;
        e.wdata    = wdata;
        e.gap      = gap;
        e.rnd      = rnd;
        table_q.push_back(e);
    endtask

    task automatic apply_entry(input entry_t e);
        int gap;
        int waited;
        bit done;
        gap = e.gap + (e.rnd ? int'($urandom % 3) : 0);
        if (gap > 0) op_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        op       = e.op;
        op_valid = 1'b1;
        if (e.wnum != 5'd0) begin
            exp_pc.push_back(e.op.pc);
            exp_num.push_back(e.wnum);
            exp_data.push_back(e.wdata);
        end
        // hold the operation until an edge with stall low
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (stall) stall_seen++;
            else done = 1'b1;
            @(posedge clk);
            #1;
            waited++;
            if (waited > LIMIT) timeout("waiting for stall to drop");
        end
        acc_cycle = cycle;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_num.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > LIMIT) timeout("draining pending writebacks");
        end
    endtask

    initial begin
        int start_err;
        int first_acc;
        string names [1:5];
        names = '{"reset and first add", "alu operations", "forwarding",
                  "division", "register zero"};
        clk_init: begin
            rstn     = 1'b0;
            op_valid = 1'b0;
            op       = '0;
        end
        errors         = 0;
        cycle          = 0;
        first_wb_cycle = -1;
        tests_passed   = 0;
        void'($urandom(32'h66ec));

        add(1, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 1, 32'h123, 1, 32'h123, 0, 0);
        add(2, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 2, 32'h8000_0005, 2, 32'h8000_0005, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_SUB,    0, 0, 2, 1, 3, 0, 3, 32'h7fff_fee2, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_SLT,    0, 0, 2, 1, 4, 0, 4, 32'h1, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_SLTU,   0, 0, 2, 1, 5, 0, 5, 32'h0, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_AND,    0, 1, 2, 0, 6, 32'hff, 6, 32'h5, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_OR,     0, 1, 1, 0, 7, 32'hf000, 7, 32'hf123, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_NOR,    0, 0, 1, 0, 8, 0, 8, 32'hffff_fedc, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_XOR,    0, 0, 2, 1, 9, 0, 9, 32'h8000_0126, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_SLL,    0, 1, 1, 0, 10, 32'h24, 10, 32'h1230, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_SRL,    0, 1, 2, 0, 11, 32'h4, 11, 32'h0800_0000, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_SRA,    0, 1, 2, 0, 12, 32'h4, 12, 32'hf800_0000, 0, 1);
        add(2, U_ALU, core_isa_pkg::ALU_PASS_B, 0, 1, 0, 0, 13, 32'hdead_beef, 13, 32'hdead_beef, 0, 1);
        // entry 13 sits at pc 0x1c000034
        add(2, U_ALU, core_isa_pkg::ALU_ADD,    1, 2, 0, 0, 14, 0, 14, 32'h1c00_0038, 0, 1);
        add(3, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 15, 32'ha, 15, 32'ha, 0, 0);
        add(3, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 15, 0, 15, 32'h1, 15, 32'hb, 0, 0);
        add(3, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 16, 32'h100, 16, 32'h100, 0, 0);
        add(3, U_ALU, core_isa_pkg::ALU_ADD,    0, 0, 15, 16, 17, 0, 17, 32'h10b, 0, 0);
        add(3, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 18, 32'h7, 18, 32'h7, 0, 0);
        add(3, U_ALU, core_isa_pkg::ALU_ADD,    0, 0, 16, 17, 19, 0, 19, 32'h20b, 0, 0);
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 20, 32'hffff_fff9, 20, 32'hffff_fff9, 0, 1);
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 21, 32'h2, 21, 32'h2, 0, 1);
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 22, 32'h8000_0000, 22, 32'h8000_0000, 0, 1);
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 23, 32'hffff_ffff, 23, 32'hffff_ffff, 0, 1);
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 3, 32'h7, 3, 32'h7, 0, 1);
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 4, 32'hffff_fffe, 4, 32'hffff_fffe, 0, 1);
        add(4, U_DIV, D_DIV,  0, 0, 3, 21, 5, 0, 5, 32'h3, 0, 1);
        add(4, U_DIV, D_MOD,  0, 0, 3, 21, 6, 0, 6, 32'h1, 0, 1);
        // positive dividend over negative divisor
        add(4, U_DIV, D_DIV,  0, 0, 3, 4, 7, 0, 7, 32'hffff_fffd, 0, 1);
        add(4, U_DIV, D_MOD,  0, 0, 3, 4, 8, 0, 8, 32'h1, 0, 1);
        add(4, U_DIV, D_DIV,  0, 0, 20, 21, 24, 0, 24, 32'hffff_fffd, 0, 1);
        add(4, U_DIV, D_MOD,  0, 0, 20, 21, 25, 0, 25, 32'hffff_ffff, 0, 1);
        add(4, U_DIV, D_DIVU, 0, 0, 20, 21, 26, 0, 26, 32'h7fff_fffc, 0, 1);
        add(4, U_DIV, D_MODU, 0, 0, 20, 21, 27, 0, 27, 32'h1, 0, 1);
        add(4, U_DIV, D_DIV,  0, 0, 20, 0, 28, 0, 28, 32'hffff_ffff, 0, 1);
        add(4, U_DIV, D_MOD,  0, 0, 20, 0, 29, 0, 29, 32'hffff_fff9, 0, 1);
        add(4, U_DIV, D_MOD,  0, 0, 22, 23, 31, 0, 31, 32'h0, 0, 1);
        add(4, U_DIV, D_DIV,  0, 0, 22, 23, 30, 0, 30, 32'h8000_0000, 0, 0);
        // uses the quotient straight from X1
        add(4, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 30, 0, 1, 32'h1, 1, 32'h8000_0001, 0, 0);
        add(5, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 1, 0, 0, 32'h5, 0, 32'h0, 0, 0);
        add(5, U_ALU, core_isa_pkg::ALU_ADD,    0, 1, 0, 0, 2, 32'h55, 2, 32'h55, 0, 0);

        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int t = 1; t <= 5; t++) begin
            start_err  = errors;
            stall_seen = 0;
            first_acc  = -1;
            if (t == 1) begin
                if (stall !== 1'b0) begin
                    $display("MISMATCH stall exp 0x0 got 0x%h", stall);
                    errors++;
                end
                if (wb_dbg.rf_wen !== 4'h0) begin
                    $display("MISMATCH rf_wen exp 0x0 got 0x%h", wb_dbg.rf_wen);
                    errors++;
                end
            end
            foreach (table_q[i]) begin
                if (table_q[i].test == t) begin
                    apply_entry(table_q[i]);
                    if (first_acc < 0) first_acc = acc_cycle;
                end
            end
            op_valid = 1'b0;
            drain();
            if (t == 1 && first_wb_cycle - first_acc != 2) begin
                $display("MISMATCH wb_latency exp 0x2 got 0x%h", first_wb_cycle - first_acc);
                errors++;
            end
            if (t == 4 && stall_seen == 0) begin
                $display("stall never went high while a divide waited in X0");
                errors++;
            end
            // no late write may follow
            repeat (5) @(posedge clk);
            #1;
            if (errors == start_err) begin
                tests_passed++;
                $display("test %0d %s: ok", t, names[t]);
            end else begin
                $display("test %0d %s: %0d errors", t, names[t], errors - start_err);
            end
        end

        $display("tests passed %0d of 5, errors %0d", tests_passed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/core_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/regfile.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/div_ctrl.sv
rtl/div_datapath.sv
rtl/exe_pipe.sv
rtl/core_top.sv
verif/core_tb.sv

// File: Bender.yml
package:
  name: core_exe

sources:
  - rtl/core_isa_pkg.sv
  - rtl/core_pipe_pkg.sv
  - rtl/regfile.sv
  - rtl/operand_select.sv
  - rtl/alu.sv
  - rtl/div_ctrl.sv
  - rtl/div_datapath.sv
  - rtl/exe_pipe.sv
  - rtl/core_top.sv
  - target: test
    files:
      - verif/core_tb.sv
